// ==== build.f ====
+incdir+include
design/mldsa_types_pkg.sv
design/mem_bus_pkg.sv
design/t1_unpacker.sv
design/poly_mem_arbiter.sv
design/poly_mem.sv
design/poly_host_reader.sv
design/pk_decode_top.sv
sim/pk_decode_tb.sv

// ==== Bender.yml ====
package:
  name: pk_decode

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/mldsa_types_pkg.sv
      - design/mem_bus_pkg.sv
      - design/t1_unpacker.sv
      - design/poly_mem_arbiter.sv
      - design/poly_mem.sv
      - design/poly_host_reader.sv
      - design/pk_decode_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/pk_decode_tb.sv

// ==== sim/pk_decode_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "pk_consts.svh"

module pk_decode_tb;
    import mldsa_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int unsigned SEED = 32'hc6ac67e0;
    localparam int SRC_MEM_DEPTH = 512;
    localparam int DEC_WORDS     = 2 * `PK_SRC_WORDS;

    // Budget covers zeroized decode as a full one
    localparam int NUM_DECODES    = 5;
    localparam int NUM_READS      = 4 * DEC_WORDS;
    localparam int TIMEOUT_CYCLES = NUM_DECODES * `PK_SRC_WORDS * 16 + NUM_READS * 16 + 2000;

    logic       clk;
    logic       reset_n;
    logic       start;
    logic       zeroize;
    src_addr_t  src_base;
    mem_addr_t  dest_base;
    logic       busy;
    logic       done;
    src_addr_t  src_rd_addr;
    t1_word_t   src_rd_data;
    logic       host_req;
    mem_addr_t  host_addr;
    logic       host_ack;
    mem_word_t  host_data;

    t1_word_t    src_mem [SRC_MEM_DEPTH];
    mem_word_t   exp_mem [`PK_MEM_WORDS];
    src_addr_t   src_addr_q;
    int          word_errs;
    int          bit_errs;
    int          other_errs;
    int          cycle_cnt;
    logic        decode_running;
    int unsigned seed_val;

    pk_decode_top u_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .start       (start),
        .src_base    (src_base),
        .dest_base   (dest_base),
        .zeroize     (zeroize),
        .busy        (busy),
        .done        (done),
        .src_rd_addr (src_rd_addr),
        .src_rd_data (src_rd_data),
        .host_req    (host_req),
        .host_addr   (host_addr),
        .host_ack    (host_ack),
        .host_data   (host_data)
    );

    always #20 clk = ~clk;

    // Source memory model, one cycle of read latency
    always @(posedge clk) begin
        #1;
        src_rd_data = src_mem[src_addr_q];
        src_addr_q  = src_rd_addr;
    end

    // ==============================
    // Checks and reference model
    // ==============================
    task automatic check_word(input string name, input mem_word_t got, input mem_word_t exp);
        if (got !== exp) begin
            word_errs++;
            $display("Fail t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            bit_errs++;
            $display("Fail t=%0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Half h of a source word, each 10-bit field moved up by the shift
    function automatic mem_word_t expand_half(input t1_word_t w, input int h);
        mem_word_t r;
        t1_coeff_t field;
        for (int j = 0; j < `PK_COEFF_PER_WORD; j++) begin
            field = w[(4 * h + j) * `PK_T1_BITS +: `PK_T1_BITS];
            r[j]  = coeff_t'(field) * (1 << `PK_SHIFT);
        end
        return r;
    endfunction

    task automatic update_model(input src_addr_t sb, input mem_addr_t db);
        mem_addr_t a;
        for (int i = 0; i < `PK_SRC_WORDS; i++) begin
            for (int h = 0; h < 2; h++) begin
                a = mem_addr_t'(int'(db) + 2 * i + h);
                exp_mem[a] = expand_half(src_mem[int'(sb) + i], h);
            end
        end
    endtask

    // ==============================
    // Bus tasks
    // ==============================
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic start_pulse(input src_addr_t sb, input mem_addr_t db);
        @(posedge clk);
        #1;
        start     = 1'b1;
        src_base  = sb;
        dest_base = db;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_bit("busy", busy, 1'b1);
    endtask

    task automatic do_decode(input src_addr_t sb, input mem_addr_t db);
        start_pulse(sb, db);
        do begin
            @(posedge clk);
            #1;
        end while (!done);
        @(posedge clk);
        #1;
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        update_model(sb, db);
    endtask

    task automatic host_read(input mem_addr_t addr, output mem_word_t data);
        @(posedge clk);
        #1;
        host_req  = 1'b1;
        host_addr = addr;
        do begin
            @(posedge clk);
            #1;
        end while (!host_ack);
        data     = host_data;
        host_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (host_ack);
    endtask

    task automatic verify_range(input mem_addr_t base, input int count);
        mem_word_t got;
        mem_addr_t a;
        for (int k = 0; k < count; k++) begin
            a = mem_addr_t'(int'(base) + k);
            host_read(a, got);
            check_word($sformatf("host_data[%0d]", a), got, exp_mem[a]);
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic reset_state_test();
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("host_ack", host_ack, 1'b0);
    endtask

    task automatic full_decode_test();
        do_decode(16'd0, 10'd0);
        verify_range(10'd0, DEC_WORDS);
    endtask

    // Fill wraps past the top of memory
    task automatic offset_decode_test();
        do_decode(16'd32, 10'd600);
        verify_range(10'd600, DEC_WORDS);
    endtask

    // Reads of the lower half while the decode fills the upper half
    task automatic contention_test();
        mem_word_t got;
        mem_addr_t a;
        int        overlap_reads;
        overlap_reads  = 0;
        a              = '0;
        decode_running = 1'b1;
        fork
            begin
                do_decode(16'd64, 10'd512);
                decode_running = 1'b0;
            end
            begin
                while (decode_running) begin
                    host_read(a, got);
                    // Read served while the unpacker still competes for the memory
                    if (busy) begin
                        overlap_reads++;
                    end
                    check_word($sformatf("host_data[%0d]", a), got, exp_mem[a]);
                    a = mem_addr_t'((int'(a) + 1) % DEC_WORDS);
                end
            end
        join
        if (overlap_reads == 0) begin
            other_errs++;
            $display("No host read completed while the decode was busy");
        end
        verify_range(10'd512, DEC_WORDS);
    endtask

    task automatic zeroize_test();
        logic done_seen;
        done_seen = 1'b0;
        start_pulse(16'd16, 10'd0);
        wait_cycles(300);
        check_bit("busy", busy, 1'b1);
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        check_bit("busy", busy, 1'b0);
        repeat (64) begin
            @(posedge clk);
            #1;
            if (done) begin
                done_seen = 1'b1;
            end
        end
        if (done_seen) begin
            other_errs++;
            $display("Done pulsed after the decode was aborted by zeroize");
        end
        do_decode(16'd8, 10'd0);
        verify_range(10'd0, DEC_WORDS);
    endtask

    task automatic finish_run();
        $display("Errors: word=%0d bit=%0d other=%0d", word_errs, bit_errs, other_errs);
        if (word_errs + bit_errs + other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        start       = 1'b0;
        zeroize     = 1'b0;
        src_base    = '0;
        dest_base   = '0;
        src_rd_data = '0;
        host_req    = 1'b0;
        host_addr   = '0;
        src_addr_q  = '0;
        word_errs   = 0;
        bit_errs    = 0;
        other_errs  = 0;

        seed_val = $urandom(SEED);
        for (int a = 0; a < SRC_MEM_DEPTH; a++) begin
            src_mem[a] = t1_word_t'({$urandom, $urandom, $urandom});
        end

        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;

        reset_state_test();
        full_decode_test();
        offset_decode_test();
        contention_test();
        zeroize_test();
        finish_run();
    end

    // Run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        other_errs++;
        $display("Timeout after %0d cycles, the DUT did not finish", cycle_cnt);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== design/pk_decode_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module pk_decode_top (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         start,
    input  wire mldsa_types_pkg::src_addr_t src_base,
    input  wire mem_bus_pkg::mem_addr_t     dest_base,
    input  wire                         zeroize,
    output logic                        busy,
    output logic                        done,
    output mldsa_types_pkg::src_addr_t  src_rd_addr,
    input  wire mldsa_types_pkg::t1_word_t  src_rd_data,
    input  wire                         host_req,
    input  wire mem_bus_pkg::mem_addr_t     host_addr,
    output logic                        host_ack,
    output mem_bus_pkg::mem_word_t      host_data
);
    import mem_bus_pkg::*;

    // Unpacker channel
    logic      upk_req;
    logic      upk_ack;
    mem_addr_t upk_addr;
    mem_word_t upk_wdata;

    // Reader channel
    logic      rd_req;
    logic      rd_ack;
    mem_addr_t rd_addr;
    mem_word_t rd_data;

    // Memory port
    logic      mem_en;
    logic      mem_we;
    mem_addr_t mem_addr;
    mem_word_t mem_wdata;
    mem_word_t mem_rdata;

    t1_unpacker u_unpacker (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .start       (start),
        .src_base    (src_base),
        .dest_base   (dest_base),
        .src_rd_data (src_rd_data),
        .upk_ack     (upk_ack),
        .src_rd_addr (src_rd_addr),
        .upk_req     (upk_req),
        .upk_addr    (upk_addr),
        .upk_wdata   (upk_wdata),
        .busy        (busy),
        .done        (done)
    );

    poly_host_reader u_host_reader (
        .clk       (clk),
        .reset_n   (reset_n),
        .host_req  (host_req),
        .host_addr (host_addr),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data),
        .host_ack  (host_ack),
        .host_data (host_data),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr)
    );

    poly_mem_arbiter u_arbiter (
        .clk       (clk),
        .reset_n   (reset_n),
        .upk_req   (upk_req),
        .upk_addr  (upk_addr),
        .upk_wdata (upk_wdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .mem_rdata (mem_rdata),
        .upk_ack   (upk_ack),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    poly_mem u_poly_mem (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== design/poly_host_reader.sv ====
`default_nettype none
`timescale 1ns/1ps

module poly_host_reader (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     host_req,
    input  wire mem_bus_pkg::mem_addr_t host_addr,
    input  wire                     rd_ack,
    input  wire mem_bus_pkg::mem_word_t rd_data,
    output logic                    host_ack,
    output mem_bus_pkg::mem_word_t  host_data,
    output logic                    rd_req,
    output mem_bus_pkg::mem_addr_t  rd_addr
);

    typedef enum logic [1:0] {
        HR_IDLE,
        HR_WAIT,
        HR_LATCH,
        HR_HOLD
    } hr_state_t;

    hr_state_t state;

    // ==============================
    // Bridge FSM
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= HR_IDLE;
            rd_req   <= 1'b0;
            host_ack <= 1'b0;
        end else begin
            case (state)
                HR_IDLE: begin
                    // Previous arbiter ack must be gone first
                    if (host_req && !rd_ack) begin
                        rd_req <= 1'b1;
                        state  <= HR_WAIT;
                    end
                end
                HR_WAIT: begin
                    if (rd_ack) begin
                        rd_req <= 1'b0;
                        state  <= HR_LATCH;
                    end
                end
                HR_LATCH: begin
                    host_ack <= 1'b1;
                    state    <= HR_HOLD;
                end
                HR_HOLD: begin
                    if (!host_req) begin
                        host_ack <= 1'b0;
                        state    <= HR_IDLE;
                    end
                end
                default: begin
                    state <= HR_IDLE;
                end
            endcase
        end
    end

    // Address and returned word
    always_ff @(posedge clk) begin
        if (state == HR_IDLE && host_req) begin
            rd_addr <= host_addr;
        end
        if (state == HR_WAIT && rd_ack) begin
            host_data <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/poly_mem.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "pk_consts.svh"

module poly_mem (
    input  wire                     clk,
    input  wire                     mem_en,
    input  wire                     mem_we,
    input  wire mem_bus_pkg::mem_addr_t mem_addr,
    input  wire mem_bus_pkg::mem_word_t mem_wdata,
    output mem_bus_pkg::mem_word_t  mem_rdata
);
    import mem_bus_pkg::*;

    // ==============================
    // Storage
    // ==============================
    mem_word_t mem_array [`PK_MEM_WORDS];

    // Single port, read data registered one cycle after the access
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem_array[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem_array[mem_addr];
            end
        end
    end

    // Read output keeps its value until the next enabled read

endmodule

`default_nettype wire

// ==== design/poly_mem_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module poly_mem_arbiter (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     upk_req,
    input  wire mem_bus_pkg::mem_addr_t upk_addr,
    input  wire mem_bus_pkg::mem_word_t upk_wdata,
    input  wire                     rd_req,
    input  wire mem_bus_pkg::mem_addr_t rd_addr,
    input  wire mem_bus_pkg::mem_word_t mem_rdata,
    output logic                    upk_ack,
    output logic                    rd_ack,
    output mem_bus_pkg::mem_word_t  rd_data,
    output logic                    mem_en,
    output logic                    mem_we,
    output mem_bus_pkg::mem_addr_t  mem_addr,
    output mem_bus_pkg::mem_word_t  mem_wdata
);
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ACCESS,
        ARB_CAPTURE,
        ARB_ACK
    } arb_state_t;

    arb_state_t state;
    mem_op_t    op_q;
    logic       last_rd;
    logic       pick_rd;
    logic       grant_now;
    logic       gnt_rd;
    logic       gnt_req;

    // Round robin, reader wins a tie unless it was served last
    assign pick_rd   = rd_req && (!upk_req || !last_rd);
    assign grant_now = (state == ARB_IDLE) && (upk_req || rd_req);

    assign gnt_rd  = (op_q == MEM_READ);
    assign gnt_req = gnt_rd ? rd_req : upk_req;

    assign mem_en = (state == ARB_ACCESS);
    assign mem_we = mem_en && (op_q == MEM_WRITE);

    // ==============================
    // Grant and handshake FSM
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= ARB_IDLE;
            op_q    <= MEM_READ;
            last_rd <= 1'b0;
            upk_ack <= 1'b0;
            rd_ack  <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (grant_now) begin
                        op_q    <= pick_rd ? MEM_READ : MEM_WRITE;
                        last_rd <= pick_rd;
                        state   <= ARB_ACCESS;
                    end
                end
                ARB_ACCESS: begin
                    state <= ARB_CAPTURE;
                end
                ARB_CAPTURE: begin
                    // Requester gone (zeroize), write is done so skip the ack
                    if (gnt_req) begin
                        upk_ack <= !gnt_rd;
                        rd_ack  <= gnt_rd;
                        state   <= ARB_ACK;
                    end else begin
                        state <= ARB_IDLE;
                    end
                end
                ARB_ACK: begin
                    if (!gnt_req) begin
                        upk_ack <= 1'b0;
                        rd_ack  <= 1'b0;
                        state   <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // Request payload held for the whole grant
    always_ff @(posedge clk) begin
        if (grant_now) begin
            mem_addr  <= pick_rd ? rd_addr : upk_addr;
            mem_wdata <= upk_wdata;
        end
        if (state == ARB_CAPTURE && gnt_rd) begin
            rd_data <= mem_rdata;
        end
    end

    // ==============================
    // Assertions
    // ==============================
    a_one_ack: assert property (@(posedge clk) disable iff (!reset_n)
        !(upk_ack && rd_ack))
        else $error("both acks high");

    a_upk_ack_has_req: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(upk_ack) |-> $past(upk_req))
        else $error("upk_ack rose without upk_req");

    a_rd_ack_has_req: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(rd_ack) |-> $past(rd_req))
        else $error("rd_ack rose without rd_req");

endmodule

`default_nettype wire

// ==== design/t1_unpacker.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "pk_consts.svh"

module t1_unpacker (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         zeroize,
    input  wire                         start,
    input  wire mldsa_types_pkg::src_addr_t src_base,
    input  wire mem_bus_pkg::mem_addr_t     dest_base,
    input  wire mldsa_types_pkg::t1_word_t  src_rd_data,
    input  wire                         upk_ack,
    output mldsa_types_pkg::src_addr_t  src_rd_addr,
    output logic                        upk_req,
    output mem_bus_pkg::mem_addr_t      upk_addr,
    output mem_bus_pkg::mem_word_t      upk_wdata,
    output logic                        busy,
    output logic                        done
);
    import mldsa_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int CNT_BITS = $clog2(`PK_SRC_WORDS);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_CAPTURE,
        ST_WR_LO,
        ST_WR_HI,
        ST_NEXT,
        ST_DONE
    } upk_state_t;

    upk_state_t                                state;
    src_addr_t                                 src_base_q;
    mem_addr_t                                 dest_base_q;
    logic [CNT_BITS-1:0]                       word_cnt;
    t1_word_t                                  src_word_q;
    logic                                      acked;
    logic                                      hi_sel;
    logic                                      last_word;
    logic [`PK_COEFF_PER_WORD*`PK_T1_BITS-1:0] half_word;

    // ==============================
    // Addressing and status
    // ==============================
    assign hi_sel    = (state == ST_WR_HI);
    assign last_word = (word_cnt == CNT_BITS'(`PK_SRC_WORDS - 1));

    assign busy = (state != ST_IDLE);
    assign done = (state == ST_DONE);

    assign src_rd_addr = src_base_q + src_addr_t'(word_cnt);

    // Word i lands at dest_base + 2i, its upper half one above
    assign upk_addr = dest_base_q + mem_addr_t'({word_cnt, hi_sel});

    // ==============================
    // Coefficient expansion
    // ==============================
    assign half_word = hi_sel ? src_word_q[`PK_T1_PER_WORD*`PK_T1_BITS-1 -: $bits(half_word)]
                              : src_word_q[$bits(half_word)-1:0];

    always_comb begin
        for (int j = 0; j < `PK_COEFF_PER_WORD; j++) begin
            // Widen first so the shift keeps the upper bits
            upk_wdata[j] = coeff_t'(t1_coeff_t'(half_word[j*`PK_T1_BITS +: `PK_T1_BITS]))
                           << `PK_SHIFT;
        end
    end

    // Captured source word, wiped on zeroize
    always_ff @(posedge clk) begin
        if (zeroize) begin
            src_word_q <= '0;
        end else if (state == ST_CAPTURE) begin
            src_word_q <= src_rd_data;
        end
    end

    // ==============================
    // Control FSM
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= ST_IDLE;
            src_base_q  <= '0;
            dest_base_q <= '0;
            word_cnt    <= '0;
            upk_req     <= 1'b0;
            acked       <= 1'b0;
        end else if (zeroize) begin
            state       <= ST_IDLE;
            src_base_q  <= '0;
            dest_base_q <= '0;
            word_cnt    <= '0;
            upk_req     <= 1'b0;
            acked       <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        src_base_q  <= src_base;
                        dest_base_q <= dest_base;
                        word_cnt    <= '0;
                        state       <= ST_READ;
                    end
                end
                ST_READ: begin
                    state <= ST_CAPTURE;
                end
                ST_CAPTURE: begin
                    state <= ST_WR_LO;
                end
                ST_WR_LO, ST_WR_HI: begin
                    if (!acked) begin
                        // A stale ack from an aborted write must fall before a new req
                        if (!upk_req && !upk_ack) begin
                            upk_req <= 1'b1;
                        end else if (upk_req && upk_ack) begin
                            upk_req <= 1'b0;
                            acked   <= 1'b1;
                        end
                    end else if (!upk_ack) begin
                        acked <= 1'b0;
                        if (state == ST_WR_LO) begin
                            state <= ST_WR_HI;
                        end else if (last_word) begin
                            state <= ST_DONE;
                        end else begin
                            state <= ST_NEXT;
                        end
                    end
                end
                ST_NEXT: begin
                    word_cnt <= word_cnt + 1'b1;
                    state    <= ST_READ;
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ==============================
    // Assertions
    // ==============================
    a_wr_payload_stable: assert property (@(posedge clk) disable iff (!reset_n)
        upk_req && !upk_ack |=> !upk_req || ($stable(upk_addr) && $stable(upk_wdata)))
        else $error("write payload changed while request was open");

    a_no_start_when_busy: assert property (@(posedge clk) disable iff (!reset_n)
        busy |-> !start)
        else $error("start seen while unpacker busy");

endmodule

`default_nettype wire

// ==== design/mem_bus_pkg.sv ====
`default_nettype none

`include "pk_consts.svh"

// ==============================
// Polynomial memory bus types
// ==============================
package mem_bus_pkg;

    typedef logic [`PK_MEM_ADDR_BITS-1:0] mem_addr_t;

    // Four stored coefficients per word, coefficient 0 in the low bits
    typedef mldsa_types_pkg::coeff_t [`PK_COEFF_PER_WORD-1:0] mem_word_t;

    // Operation carried by a granted request
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

endpackage

`default_nettype wire

// ==== design/mldsa_types_pkg.sv ====
`default_nettype none

`include "pk_consts.svh"

// ==============================
// ML-DSA coefficient and public key word types
// ==============================
package mldsa_types_pkg;

    // Coefficient after expansion, as stored in polynomial memory
    typedef logic [`PK_COEFF_BITS-1:0] coeff_t;

    // One packed t1 field as it arrives from the key
    typedef logic [`PK_T1_BITS-1:0] t1_coeff_t;

    // Eight packed t1 fields, field 0 in the low bits
    typedef logic [`PK_T1_PER_WORD*`PK_T1_BITS-1:0] t1_word_t;

    // Source memory address
    typedef logic [`PK_SRC_ADDR_BITS-1:0] src_addr_t;

endpackage

`default_nettype wire

// ==== include/pk_consts.svh ====
`ifndef PK_CONSTS_SVH
`define PK_CONSTS_SVH

// Public key layout
`define PK_K              8
`define PK_N              256

// Coefficient geometry
`define PK_T1_BITS        10
`define PK_SHIFT          13
`define PK_COEFF_BITS     24
`define PK_T1_PER_WORD    8
`define PK_COEFF_PER_WORD 4

// Address spaces
`define PK_SRC_ADDR_BITS  16
`define PK_MEM_ADDR_BITS  10
`define PK_SRC_WORDS      ((`PK_K * `PK_N) / `PK_T1_PER_WORD)
`define PK_MEM_WORDS      1024

`endif
